//--- common/weights_pkg.sv
package weights_pkg;

  ////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////

  localparam int WORD_W  = 512;  // memory and buffer word
  localparam int ADR_W   = 16;   // external memory / cfg address
  localparam int BANK_AW = 12;   // 4096 words per bank

  localparam int INT8_LANES         = 64;   // 8 bit weights per step
  localparam int BIN_LANES          = 128;  // 1 bit weights per step
  localparam int BIN_STEPS_PER_WORD = 4;    // binary steps packed per word

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  typedef enum logic
  {
    MODE_INT8,  // one step per word
    MODE_BIN    // four steps per word
  } weights_mode_e;

  typedef enum logic [1:0]
  {
    LOAD_IDLE,   // waiting for start
    LOAD_REQ,    // issuing reads
    LOAD_DRAIN   // waiting on last returns
  } load_state_e;

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  typedef struct packed
  {
    weights_mode_e      mode;
    logic [15:0]        nif_k_k;   // nif * k * k
    logic [15:0]        of;        // output channels of layer
    logic [ADR_W-1:0]   base_adr;  // layer base in ext memory
  } weights_cfg_t;

  typedef struct packed
  {
    logic               en;
    logic [BANK_AW-1:0] adr;
    logic [WORD_W-1:0]  data;
  } buf_wr_t;

  typedef struct packed
  {
    logic               en;
    logic [BANK_AW-1:0] adr;
  } buf_rd_t;

  typedef struct packed
  {
    logic               en;
    logic               wr;   // 1 = write, 0 = read
    logic [BANK_AW-1:0] adr;
    logic [WORD_W-1:0]  din;
  } bank_port_t;

endpackage

//--- weights_buffer/weights_bank.sv
module weights_bank import weights_pkg::*;
(
  input  logic              clk,
  input  bank_port_t        port,
  output logic [WORD_W-1:0] dout   // valid one cycle after a read
);

  localparam int DEPTH = 1 << BANK_AW;  // 4096 words

  logic [WORD_W-1:0] mem [0:DEPTH-1];

  ////////////////////////////////////////
  // single port, read or write per cycle
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (port.en)
    begin
      if (port.wr)
        mem[port.adr] <= port.din;  // write, dout holds
      else
        dout <= mem[port.adr];      // registered read
    end
  end

endmodule

//--- weights_buffer/weights_ping_pong.sv
module weights_ping_pong import weights_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              conv_load_weights,  // swap halves
  input  weights_mode_e     load_mode,          // mode of the tile now loading
  input  buf_wr_t           buf_wr,
  input  buf_rd_t           buf_rd,
  output logic [WORD_W-1:0] rd_data,
  output weights_mode_e     rd_mode             // mode of readable bank
);

  logic              sel;       // 1 = write pong / read ping
  logic              sel_q;     // sel of the read now returning
  weights_mode_e     mode_ping;
  weights_mode_e     mode_pong;
  bank_port_t        port_ping;
  bank_port_t        port_pong;
  logic [WORD_W-1:0] dout_ping;
  logic [WORD_W-1:0] dout_pong;

  ////////////////////////////////////////
  // swap control
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sel       <= 1'b0;
      sel_q     <= 1'b0;
      mode_ping <= MODE_INT8;
      mode_pong <= MODE_INT8;
    end
    else
    begin
      sel_q <= sel;  // follows the read issued this cycle
      if (conv_load_weights)
      begin
        sel <= ~sel;
        if (sel)
          mode_ping <= load_mode;  // ping becomes the write bank
        else
          mode_pong <= load_mode;  // pong becomes the write bank
      end
    end
  end

  ////////////////////////////////////////
  // port steering
  ////////////////////////////////////////

  always_comb
  begin
    if (sel)
    begin
      port_pong = '{en: buf_wr.en, wr: 1'b1, adr: buf_wr.adr, din: buf_wr.data};
      port_ping = '{en: buf_rd.en, wr: 1'b0, adr: buf_rd.adr, din: '0};
    end
    else
    begin
      port_ping = '{en: buf_wr.en, wr: 1'b1, adr: buf_wr.adr, din: buf_wr.data};
      port_pong = '{en: buf_rd.en, wr: 1'b0, adr: buf_rd.adr, din: '0};
    end
  end

  weights_bank bank_ping
  (
    .clk  (clk),
    .port (port_ping),
    .dout (dout_ping)
  );

  weights_bank bank_pong
  (
    .clk  (clk),
    .port (port_pong),
    .dout (dout_pong)
  );

  // mux on delayed select so a swap does not tear the word
  assign rd_data = sel_q ? dout_ping : dout_pong;
  assign rd_mode = sel_q ? mode_ping : mode_pong;

endmodule

//--- hw/weights_load_ctrl.sv
module weights_load_ctrl import weights_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                conv_load_weights,  // start pulse
  input  weights_cfg_t        cfg,
  input  logic                ddr_ready,          // memory takes a read this cycle
  input  logic                ddr_valid,          // return strobe
  input  logic [WORD_W-1:0]   ddr_data,
  output logic                ddr_rd_en,
  output logic [ADR_W-1:0]    ddr_rd_adr,
  output buf_wr_t             buf_wr,
  output logic                load_busy
);

  load_state_e      state;
  logic             start;        // accepted start
  logic [16:0]      wpt_sum;      // nif_k_k + 3 without overflow
  logic [15:0]      wpt_next;     // words per tile from live cfg
  logic [ADR_W-1:0] base_next;    // tile base from live cfg

  weights_mode_e    mode_q;       // latched cfg
  logic [15:0]      of_q;
  logic [15:0]      wpt;          // words per tile, latched
  logic [ADR_W-1:0] tile_base;

  logic [15:0]      req_cnt;      // word number of next request
  logic [15:0]      ret_cnt;      // returns written so far
  logic [15:0]      tile_idx;
  logic [31:0]      covered;      // channels covered after this tile
  logic             tile_wrap;
  logic             last_req;
  logic             last_ret;

  ////////////////////////////////////////
  // tile geometry
  ////////////////////////////////////////

  assign start     = conv_load_weights && (state == LOAD_IDLE);
  assign wpt_sum   = {1'b0, cfg.nif_k_k} + 17'd3;
  assign wpt_next  = (cfg.mode == MODE_BIN) ? {1'b0, wpt_sum[16:2]} : cfg.nif_k_k; // ceil /4
  assign base_next = cfg.base_adr + tile_idx * wpt_next;  // base + tile * wpt

  assign covered   = (32'(tile_idx) + 32'd1)
                   * ((mode_q == MODE_BIN) ? 32'(BIN_LANES) : 32'(INT8_LANES));
  assign tile_wrap = covered >= 32'(of_q);  // all of channels done

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      mode_q    <= cfg.mode;
      of_q      <= cfg.of;
      wpt       <= wpt_next;
      tile_base <= base_next;
    end
  end

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  assign ddr_rd_en  = (state == LOAD_REQ) && ddr_ready;  // held off by back-pressure
  assign ddr_rd_adr = tile_base + req_cnt;
  assign last_req   = ddr_rd_en && (req_cnt == wpt - 16'd1);
  assign last_ret   = ddr_valid && (ret_cnt == wpt - 16'd1);
  assign load_busy  = (state != LOAD_IDLE);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= LOAD_IDLE;
      req_cnt  <= '0;
      tile_idx <= '0;
    end
    else
    begin
      case (state)
        LOAD_IDLE:
        begin
          if (start)
          begin
            req_cnt <= '0;
            state   <= (wpt_next == 16'd0) ? LOAD_IDLE : LOAD_REQ;  // empty tile stays idle
          end
        end
        LOAD_REQ:
        begin
          if (ddr_rd_en)
            req_cnt <= req_cnt + 16'd1;  // word number holds while not ready
          if (last_req)
            state <= LOAD_DRAIN;
        end
        LOAD_DRAIN:
        begin
          if (last_ret)
          begin
            state    <= LOAD_IDLE;  // busy falls next cycle
            tile_idx <= tile_wrap ? 16'd0 : tile_idx + 16'd1;
          end
        end
        default:
          state <= LOAD_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // return side
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset || start)
      ret_cnt <= '0;
    else if (buf_wr.en)
      ret_cnt <= ret_cnt + 16'd1;  // next write address
  end

  always_comb
  begin
    buf_wr.en   = ddr_valid && load_busy;  // write in the return cycle
    buf_wr.adr  = ret_cnt[BANK_AW-1:0];
    buf_wr.data = ddr_data;
  end

endmodule

//--- hw/weights_stream.sv
module weights_stream import weights_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              re_fm_en,        // one step
  input  logic              re_fm_end,       // last step of pass
  input  logic [WORD_W-1:0] rd_data,         // from buffer, one cycle after read
  input  weights_mode_e     rd_mode,
  output buf_rd_t           buf_rd,
  output logic              weights_valid,   // two cycles after re_fm_en
  output logic [WORD_W-1:0] weights_vector
);

  localparam int SLICE_W = $clog2(BIN_STEPS_PER_WORD);  // slice number bits

  logic [15:0]        step_cnt;   // step within pass
  logic [15:0]        word_idx;   // buffer word of this step
  logic               vld_q;      // read in flight
  logic [SLICE_W-1:0] slice_q;    // slice rides along with read
  logic [WORD_W-1:0]  vec_next;

  ////////////////////////////////////////
  // step counter and buffer read
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
      step_cnt <= '0;
    else if (re_fm_en)
    begin
      if (re_fm_end)
        step_cnt <= '0;              // pass done
      else
        step_cnt <= step_cnt + 16'd1;
    end
  end

  // binary packs four steps per word
  assign word_idx = (rd_mode == MODE_BIN) ? (step_cnt >> SLICE_W) : step_cnt;

  always_comb
  begin
    buf_rd.en  = re_fm_en;
    buf_rd.adr = word_idx[BANK_AW-1:0];
  end

  ////////////////////////////////////////
  // pipeline, read then slice select
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
      vld_q <= 1'b0;
    else
      vld_q <= re_fm_en;  // stage 1, bank read
  end

  always_ff @(posedge clk)
  begin
    if (re_fm_en)
      slice_q <= step_cnt[SLICE_W-1:0];  // step mod 4
  end

  always_comb
  begin
    if (rd_mode == MODE_BIN)
    begin
      vec_next = '0;  // zeros above the slice
      vec_next[BIN_LANES-1:0] = rd_data[slice_q*BIN_LANES +: BIN_LANES];
    end
    else
      vec_next = rd_data;  // int8, whole word is one step
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      weights_valid <= 1'b0;
    else
      weights_valid <= vld_q;  // stage 2
  end

  always_ff @(posedge clk)
  begin
    if (vld_q)
      weights_vector <= vec_next;
  end

endmodule

//--- hw/weights_top.sv
module weights_top import weights_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  // layer config and start
  input  weights_cfg_t      cfg,
  input  logic              conv_load_weights,
  output logic              load_busy,
  // external memory read
  input  logic              ddr_ready,
  output logic              ddr_rd_en,
  output logic [ADR_W-1:0]  ddr_rd_adr,
  input  logic              ddr_valid,
  input  logic [WORD_W-1:0] ddr_data,
  // feature map strobes
  input  logic              re_fm_en,
  input  logic              re_fm_end,
  // to processing elements
  output logic              weights_valid,
  output logic [WORD_W-1:0] weights_vector
);

  buf_wr_t           buf_wr;   // load -> buffer
  buf_rd_t           buf_rd;   // stream -> buffer
  logic [WORD_W-1:0] rd_data;  // buffer -> stream
  weights_mode_e     rd_mode;

  ////////////////////////////////////////
  // load, buffer, stream
  ////////////////////////////////////////

  weights_load_ctrl u_load
  (
    .clk               (clk),
    .reset             (reset),
    .conv_load_weights (conv_load_weights),
    .cfg               (cfg),
    .ddr_ready         (ddr_ready),
    .ddr_valid         (ddr_valid),
    .ddr_data          (ddr_data),
    .ddr_rd_en         (ddr_rd_en),
    .ddr_rd_adr        (ddr_rd_adr),
    .buf_wr            (buf_wr),
    .load_busy         (load_busy)
  );

  weights_ping_pong u_buf
  (
    .clk               (clk),
    .reset             (reset),
    .conv_load_weights (conv_load_weights),  // swap with load start
    .load_mode         (cfg.mode),           // stable around start
    .buf_wr            (buf_wr),
    .buf_rd            (buf_rd),
    .rd_data           (rd_data),
    .rd_mode           (rd_mode)
  );

  weights_stream u_stream
  (
    .clk            (clk),
    .reset          (reset),
    .re_fm_en       (re_fm_en),
    .re_fm_end      (re_fm_end),
    .rd_data        (rd_data),
    .rd_mode        (rd_mode),
    .buf_rd         (buf_rd),
    .weights_valid  (weights_valid),
    .weights_vector (weights_vector)
  );

endmodule

//--- bench/weights_tb.sv
module weights_tb import weights_pkg::*;
();

  logic              clk;
  logic              reset;
  weights_cfg_t      cfg;
  logic              conv_load_weights;
  logic              load_busy;
  logic              ddr_ready;
  logic              ddr_rd_en;
  logic [ADR_W-1:0]  ddr_rd_adr;
  logic              ddr_valid;
  logic [WORD_W-1:0] ddr_data;
  logic              re_fm_en;
  logic              re_fm_end;
  logic              weights_valid;
  logic [WORD_W-1:0] weights_vector;

  logic [31:0]       stim_seed;       // cfg, gaps
  logic [31:0]       ready_seed;      // ddr_ready pattern
  int                errors;
  int                checks;

  // reference model
  int                m_tile;          // tile index
  int                wsel;            // bank now being written
  int                loads_done;
  logic [ADR_W-1:0]  bank_base [2];   // tile start address in ext memory
  logic [15:0]       bank_steps [2];  // nif_k_k of that tile
  weights_mode_e     bank_mode [2];

  // request / return tracking
  logic [ADR_W-1:0]  exp_base;
  int                exp_wpt;
  int                req_num;
  int                ret_num;
  logic              busy_drop;       // last return seen, busy must be low next
  logic [ADR_W-1:0]  acc_q [$];       // accepted reads awaiting return
  logic [WORD_W-1:0] vec_q [$];       // expected weight vectors
  logic [1:0]        en_pipe;         // re_fm_en delayed two cycles

  weights_top DUT
  (
    .clk               (clk),
    .reset             (reset),
    .cfg               (cfg),
    .conv_load_weights (conv_load_weights),
    .load_busy         (load_busy),
    .ddr_ready         (ddr_ready),
    .ddr_rd_en         (ddr_rd_en),
    .ddr_rd_adr        (ddr_rd_adr),
    .ddr_valid         (ddr_valid),
    .ddr_data          (ddr_data),
    .re_fm_en          (re_fm_en),
    .re_fm_end         (re_fm_end),
    .weights_valid     (weights_valid),
    .weights_vector    (weights_vector)
  );

  always #5 clk = ~clk;  // period 10

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] rand_stim();
    stim_seed = lcg_next(stim_seed);
    return stim_seed >> 8;  // low bits are weak
  endfunction

  // memory word, hash of address with lane number mixed in
  function automatic logic [WORD_W-1:0] word_at(input logic [ADR_W-1:0] adr);
    logic [WORD_W-1:0] w;
    for (int i = 0; i < WORD_W / 32; i++)
      w[i*32 +: 32] = lcg_next(lcg_next({adr, 12'h0, 4'(i)}));
    return w;
  endfunction

  function automatic logic [WORD_W-1:0] exp_vector(input logic [ADR_W-1:0] base,
                                                   input int step, input weights_mode_e mode);
    logic [WORD_W-1:0] w;
    logic [WORD_W-1:0] v;
    v = '0;
    if (mode == MODE_BIN)
    begin
      w = word_at(base + ADR_W'(step / BIN_STEPS_PER_WORD));
      v[BIN_LANES-1:0] = w[(step % BIN_STEPS_PER_WORD) * BIN_LANES +: BIN_LANES];
    end
    else
      v = word_at(base + ADR_W'(step));  // whole word
    return v;
  endfunction

  task automatic check_eq(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                          input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    $display("errors: %0d, checks: %0d", errors, checks);
    $display("Verification failed");
    $finish;
  endtask

  ////////////////////////////////////////
  // memory model and monitor
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    ready_seed = lcg_next(ready_seed);
    ddr_ready = (ready_seed[23:22] != 2'b00);  // ready about 3 of 4 cycles
    if (acc_q.size() > 0)
    begin
      ddr_valid = 1'b1;  // one cycle after accept
      ddr_data  = word_at(acc_q.pop_front());
    end
    else
    begin
      ddr_valid = 1'b0;
      ddr_data  = '0;
    end
  end

  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (ddr_rd_en)
      begin
        check_eq(ddr_ready, 1'b1, "read request while ddr_ready low");
        check_eq(req_num < exp_wpt, 1'b1, "read request beyond words_per_tile");
        check_eq(ddr_rd_adr, ADR_W'(exp_base + req_num), "read request address");
        acc_q.push_back(ddr_rd_adr);
        req_num++;
      end
      if (busy_drop)
        check_eq(load_busy, 1'b0, "load_busy after last return");
      busy_drop = 1'b0;
      if (ddr_valid)
      begin
        ret_num++;
        busy_drop = (ret_num == exp_wpt);
      end
      check_eq(weights_valid, en_pipe[1], "weights_valid two cycles after re_fm_en");
      if (weights_valid && vec_q.size() > 0)
        check_eq(weights_vector, vec_q.pop_front(), "weights_vector");
      en_pipe = {en_pipe[0], re_fm_en};
    end
  end

  ////////////////////////////////////////
  // load and stream sequences
  ////////////////////////////////////////

  task automatic stream_pass(input logic [ADR_W-1:0] base, input int steps,
                             input weights_mode_e mode);
    int gap;
    int n;
    repeat (1 + rand_stim() % 3) @(negedge clk);  // let the swap settle
    for (int s = 0; s < steps; s++)
    begin
      re_fm_en  = 1'b1;
      re_fm_end = (s == steps - 1);  // closes the pass
      vec_q.push_back(exp_vector(base, s, mode));
      @(negedge clk);
      re_fm_en  = 1'b0;
      re_fm_end = 1'b0;
      gap = rand_stim() % 3;  // 0 gives back to back steps
      repeat (gap) @(negedge clk);
    end
    n = 0;
    while (vec_q.size() > 0)
    begin
      @(negedge clk);
      n++;
      if (n > 50)
        abort_run("weights_valid missing for streamed steps");
    end
  endtask

  task automatic run_load();
    int wpt;
    int lanes;
    int rd;
    int n;
    wpt   = (cfg.mode == MODE_BIN) ? (cfg.nif_k_k + 3) / 4 : cfg.nif_k_k;
    lanes = (cfg.mode == MODE_BIN) ? BIN_LANES : INT8_LANES;
    exp_wpt  = wpt;
    exp_base = ADR_W'(cfg.base_adr + m_tile * wpt);  // base + tile * wpt
    req_num  = 0;
    ret_num  = 0;
    wsel = 1 - wsel;  // swap on start
    rd   = 1 - wsel;
    bank_base[wsel]  = exp_base;
    bank_steps[wsel] = cfg.nif_k_k;
    bank_mode[wsel]  = cfg.mode;
    conv_load_weights = 1'b1;
    @(negedge clk);
    conv_load_weights = 1'b0;
    if (loads_done > 0)
      stream_pass(bank_base[rd], bank_steps[rd], bank_mode[rd]);  // previous tile
    n = 0;
    while (load_busy)
    begin
      @(negedge clk);
      n++;
      if (n > 2000)
        abort_run("load_busy did not fall after the load");
    end
    check_eq(req_num, wpt, "number of read requests");
    check_eq(ret_num, wpt, "number of returned words");
    if ((m_tile + 1) * lanes >= cfg.of)
      m_tile = 0;  // output channels covered
    else
      m_tile++;
    loads_done++;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    logic mode_bit;
    int   lanes;
    int   tiles;
    clk = 1'b0;
    reset = 1'b1;
    cfg = '0;
    conv_load_weights = 1'b0;
    ddr_ready = 1'b0;
    ddr_valid = 1'b0;
    ddr_data = '0;
    re_fm_en = 1'b0;
    re_fm_end = 1'b0;
    stim_seed = 32'd17;
    ready_seed = lcg_next(32'd17);  // own stream for ready
    errors = 0;
    checks = 0;
    m_tile = 0;
    wsel = 0;
    loads_done = 0;
    exp_base = '0;
    exp_wpt = 0;
    req_num = 0;
    ret_num = 0;
    busy_drop = 1'b0;
    en_pipe = '0;

    repeat (16) @(negedge clk);
    reset = 1'b0;
    check_eq(ddr_rd_en, 1'b0, "ddr_rd_en after reset");
    check_eq(load_busy, 1'b0, "load_busy after reset");
    check_eq(weights_valid, 1'b0, "weights_valid after reset");

    mode_bit = rand_stim() % 2;
    for (int layer = 0; layer < 6; layer++)
    begin
      cfg.mode     = weights_mode_e'(mode_bit ^ 1'(layer));  // alternate modes
      cfg.nif_k_k  = 16'(5 + rand_stim() % 36);
      cfg.of       = 16'(1 + rand_stim() % 320);
      cfg.base_adr = 16'(rand_stim());
      lanes = (cfg.mode == MODE_BIN) ? BIN_LANES : INT8_LANES;
      tiles = (cfg.of + lanes - 1) / lanes;
      @(negedge clk);  // cfg settles before start
      for (int ld = 0; ld < tiles + 1; ld++)
        run_load();  // one past the wrap
    end

    repeat (4) @(negedge clk);
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- list.f
common/weights_pkg.sv
weights_buffer/weights_bank.sv
weights_buffer/weights_ping_pong.sv
hw/weights_load_ctrl.sv
hw/weights_stream.sv
hw/weights_top.sv
bench/weights_tb.sv
